//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // RV32I major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_RELEASE
    } arb_state_e;

endpackage

//--- src/rv_decode.sv
module rv_decode (
    input  logic [rv_pkg::XLEN-1:0] instr_i,
    output logic                    reg_write_o,
    output logic                    mem_to_reg_o,
    output logic                    mem_read_o,
    output logic                    mem_write_o,
    output logic                    alu_src_imm_o,
    output logic                    branch_o,
    output logic                    jal_o,
    output logic                    jalr_o,
    output rv_pkg::alu_op_e         alu_op_o,
    output logic [rv_pkg::XLEN-1:0] imm_o
);

    rv_pkg::opcode_e           opcode;
    rv_pkg::alu_op_e           funct_op;
    logic [2:0]                funct3;
    logic [rv_pkg::XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = rv_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // OP and OP_IMM share the funct3 mapping
    always_comb begin
        case (funct3)
            3'b010:  funct_op = rv_pkg::ALU_SLT;
            3'b100:  funct_op = rv_pkg::ALU_XOR;
            3'b110:  funct_op = rv_pkg::ALU_OR;
            3'b111:  funct_op = rv_pkg::ALU_AND;
            default: funct_op = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        {reg_write_o, mem_to_reg_o, mem_read_o, mem_write_o} = 4'b0000;
        {alu_src_imm_o, branch_o, jal_o, jalr_o} = 4'b0000;
        alu_op_o = rv_pkg::ALU_ADD;
        imm_o    = imm_i;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                {reg_write_o, alu_src_imm_o} = 2'b11;
                alu_op_o = rv_pkg::ALU_PASS_B;
                imm_o    = imm_u;
            end
            rv_pkg::OPC_OP_IMM: begin
                {reg_write_o, alu_src_imm_o} = 2'b11;
                alu_op_o = funct_op;
            end
            rv_pkg::OPC_OP: begin
                reg_write_o = 1'b1;
                alu_op_o    = (funct3 == 3'b000 && instr_i[30]) ? rv_pkg::ALU_SUB : funct_op;
            end
            rv_pkg::OPC_LOAD: begin
                {reg_write_o, mem_to_reg_o, mem_read_o, alu_src_imm_o} = 4'b1111;
            end
            rv_pkg::OPC_STORE: begin
                {mem_write_o, alu_src_imm_o} = 2'b11;
                imm_o = imm_s;
            end
            rv_pkg::OPC_BRANCH: begin
                branch_o = 1'b1;
                imm_o    = imm_b;
            end
            rv_pkg::OPC_JAL: begin
                {reg_write_o, jal_o} = 2'b11;
                imm_o = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                {reg_write_o, jalr_o} = 2'b11;
            end
            // Anything else behaves as a NOP
            default: ;
        endcase
    end

endmodule

//--- src/rv_alu.sv
module rv_alu (
    input  logic [rv_pkg::XLEN-1:0] a_i,
    input  logic [rv_pkg::XLEN-1:0] b_i,
    input  rv_pkg::alu_op_e         op_i,
    output logic [rv_pkg::XLEN-1:0] result_o
);

    logic less;

    // Signed compare for SLT
    assign less = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            rv_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_pkg::ALU_SLT:    result_o = {{(rv_pkg::XLEN-1){1'b0}}, less};
            rv_pkg::ALU_PASS_B: result_o = b_i;
            default:            result_o = a_i + b_i;
        endcase
    end

endmodule

//--- src/rv_core.sv
module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                      MEM_AW   = 30
) (
    input  logic                    clk,
    input  logic                    rst_i,
    output logic                    imem_ren_o,
    output logic [MEM_AW-1:0]       imem_addr_o,
    input  logic                    imem_stall_i,
    input  logic [rv_pkg::XLEN-1:0] imem_rdata_i,
    output logic                    dmem_ren_o,
    output logic                    dmem_wen_o,
    output logic [MEM_AW-1:0]       dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    input  logic                    dmem_stall_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] pc_o
);

    localparam int XLEN = rv_pkg::XLEN;
    localparam int RAW  = rv_pkg::REG_AW;

    // Memory holds big-endian words
    function automatic logic [XLEN-1:0] swap_bytes(input logic [XLEN-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    logic            stall, load_use, redirect, br_taken;
    logic [XLEN-1:0] pc_q, if_instr, id_instr_q, id_pc_q;
    logic [XLEN-1:0] regs [2**RAW];

    logic            id_reg_write, id_mem_to_reg, id_mem_read, id_mem_write;
    logic            id_alu_src_imm, id_branch, id_jal, id_jalr;
    rv_pkg::alu_op_e id_alu_op;
    logic [XLEN-1:0] id_imm, id_rs1_val, id_rs2_val, id_jalr_sum, id_target;
    logic [RAW-1:0]  id_rs1, id_rs2, id_rd;

    logic            ex_reg_write_q, ex_mem_read_q, ex_mem_write_q;
    logic            ex_mem_to_reg_q, ex_jump_q, ex_alu_src_imm_q;
    rv_pkg::alu_op_e ex_alu_op_q;
    logic [RAW-1:0]  ex_rs1_q, ex_rs2_q, ex_rd_q;
    logic [XLEN-1:0] ex_rs1_val_q, ex_rs2_val_q, ex_imm_q, ex_pc4_q;
    logic [XLEN-1:0] ex_a, ex_b, ex_alu_out, ex_result;

    logic            mem_reg_write_q, mem_mem_read_q, mem_mem_write_q, mem_mem_to_reg_q;
    logic [RAW-1:0]  mem_rd_q, wb_rd_q;
    logic [XLEN-1:0] mem_alu_q, mem_store_q, mem_result;
    logic            wb_reg_write_q;
    logic [XLEN-1:0] wb_data_q;

    assign stall       = imem_stall_i | dmem_stall_i;
    assign imem_ren_o  = 1'b1;
    assign imem_addr_o = pc_q[MEM_AW+1:2];
    assign pc_o        = pc_q;
    assign if_instr    = swap_bytes(imem_rdata_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= RESET_PC;
            id_instr_q <= rv_pkg::NOP_INSTR;
        end else if (!stall && !load_use) begin
            pc_q       <= redirect ? id_target : pc_q + 32'd4;
            id_instr_q <= redirect ? rv_pkg::NOP_INSTR : if_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !load_use) begin
            id_pc_q <= pc_q;
        end
    end

    rv_decode u_decode (
        .instr_i       (id_instr_q),
        .reg_write_o   (id_reg_write),
        .mem_to_reg_o  (id_mem_to_reg),
        .mem_read_o    (id_mem_read),
        .mem_write_o   (id_mem_write),
        .alu_src_imm_o (id_alu_src_imm),
        .branch_o      (id_branch),
        .jal_o         (id_jal),
        .jalr_o        (id_jalr),
        .alu_op_o      (id_alu_op),
        .imm_o         (id_imm)
    );

    assign id_rs1 = id_instr_q[19:15];
    assign id_rs2 = id_instr_q[24:20];
    assign id_rd  = id_instr_q[11:7];

    // Newest producer wins, WB write is visible in the same cycle
    assign id_rs1_val = (id_rs1 == '0) ? '0 :
                        (ex_reg_write_q && ex_rd_q == id_rs1) ? ex_result :
                        (mem_reg_write_q && mem_rd_q == id_rs1) ? mem_result :
                        (wb_reg_write_q && wb_rd_q == id_rs1) ? wb_data_q : regs[id_rs1];
    assign id_rs2_val = (id_rs2 == '0) ? '0 :
                        (ex_reg_write_q && ex_rd_q == id_rs2) ? ex_result :
                        (mem_reg_write_q && mem_rd_q == id_rs2) ? mem_result :
                        (wb_reg_write_q && wb_rd_q == id_rs2) ? wb_data_q : regs[id_rs2];

    assign load_use    = ex_mem_read_q && ex_reg_write_q &&
                         (ex_rd_q == id_rs1 || ex_rd_q == id_rs2);
    // funct3 bit 0 selects BNE
    assign br_taken    = id_branch && ((id_rs1_val == id_rs2_val) != id_instr_q[12]);
    assign redirect    = !load_use && (br_taken || id_jal || id_jalr);
    assign id_jalr_sum = id_rs1_val + id_imm;
    assign id_target   = id_jalr ? {id_jalr_sum[XLEN-1:1], 1'b0} : id_pc_q + id_imm;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_reg_write_q <= 1'b0;
            ex_mem_read_q  <= 1'b0;
            ex_mem_write_q <= 1'b0;
        end else if (!stall) begin
            // Bubble on load-use, x0 is never a destination
            ex_reg_write_q <= id_reg_write && id_rd != '0 && !load_use;
            ex_mem_read_q  <= id_mem_read && !load_use;
            ex_mem_write_q <= id_mem_write && !load_use;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_mem_to_reg_q  <= id_mem_to_reg;
            ex_jump_q        <= id_jal || id_jalr;
            ex_alu_src_imm_q <= id_alu_src_imm;
            ex_alu_op_q      <= id_alu_op;
            ex_rs1_q         <= id_rs1;
            ex_rs2_q         <= id_rs2;
            ex_rd_q          <= id_rd;
            ex_rs1_val_q     <= id_rs1_val;
            ex_rs2_val_q     <= id_rs2_val;
            ex_imm_q         <= id_imm;
            ex_pc4_q         <= id_pc_q + 32'd4;
        end
    end

    assign ex_a = (mem_reg_write_q && mem_rd_q == ex_rs1_q) ? mem_result :
                  (wb_reg_write_q && wb_rd_q == ex_rs1_q) ? wb_data_q : ex_rs1_val_q;
    assign ex_b = (mem_reg_write_q && mem_rd_q == ex_rs2_q) ? mem_result :
                  (wb_reg_write_q && wb_rd_q == ex_rs2_q) ? wb_data_q : ex_rs2_val_q;

    rv_alu u_alu (
        .a_i      (ex_a),
        .b_i      (ex_alu_src_imm_q ? ex_imm_q : ex_b),
        .op_i     (ex_alu_op_q),
        .result_o (ex_alu_out)
    );

    // Link value for JAL and JALR
    assign ex_result = ex_jump_q ? ex_pc4_q : ex_alu_out;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_reg_write_q <= 1'b0;
            mem_mem_read_q  <= 1'b0;
            mem_mem_write_q <= 1'b0;
            wb_reg_write_q  <= 1'b0;
        end else if (!stall) begin
            mem_reg_write_q <= ex_reg_write_q;
            mem_mem_read_q  <= ex_mem_read_q;
            mem_mem_write_q <= ex_mem_write_q;
            wb_reg_write_q  <= mem_reg_write_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_mem_to_reg_q <= ex_mem_to_reg_q;
            mem_alu_q        <= ex_result;
            mem_store_q      <= ex_b;
            mem_rd_q         <= ex_rd_q;
            wb_rd_q          <= mem_rd_q;
            wb_data_q        <= mem_result;
        end
    end

    assign dmem_ren_o   = mem_mem_read_q;
    assign dmem_wen_o   = mem_mem_write_q;
    assign dmem_addr_o  = mem_alu_q[MEM_AW+1:2];
    assign dmem_wdata_o = swap_bytes(mem_store_q);
    assign mem_result   = mem_mem_to_reg_q ? swap_bytes(dmem_rdata_i) : mem_alu_q;

    always_ff @(posedge clk) begin
        if (!stall && wb_reg_write_q) begin
            regs[wb_rd_q] <= wb_data_q;
        end
    end

endmodule

//--- src/rv_mem_arbiter.sv
module rv_mem_arbiter #(
    parameter int MEM_AW = 30
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    imem_ren_i,
    input  logic [MEM_AW-1:0]       imem_addr_i,
    output logic                    imem_stall_o,
    output logic [rv_pkg::XLEN-1:0] imem_rdata_o,
    input  logic                    dmem_ren_i,
    input  logic                    dmem_wen_i,
    input  logic [MEM_AW-1:0]       dmem_addr_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_wdata_i,
    output logic                    dmem_stall_o,
    output logic [rv_pkg::XLEN-1:0] dmem_rdata_o,
    output logic                    mem_req_o,
    output logic                    mem_wen_o,
    output logic [MEM_AW-1:0]       mem_addr_o,
    output logic [rv_pkg::XLEN-1:0] mem_wdata_o,
    input  logic                    mem_ack_i,
    input  logic [rv_pkg::XLEN-1:0] mem_rdata_i
);

    rv_pkg::arb_state_e state_q;
    logic               i_done_q, d_done_q, serve_d_q;
    logic               i_pend, d_pend;

    assign i_pend = imem_ren_i & ~i_done_q;
    assign d_pend = (dmem_ren_i | dmem_wen_i) & ~d_done_q;

    assign imem_stall_o = i_pend;
    assign dmem_stall_o = d_pend;
    assign mem_req_o    = (state_q == rv_pkg::ARB_REQ);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= rv_pkg::ARB_IDLE;
            i_done_q  <= 1'b0;
            d_done_q  <= 1'b0;
            serve_d_q <= 1'b0;
            mem_wen_o <= 1'b0;
        end else begin
            // Core advances this cycle
            if (!i_pend && !d_pend) begin
                i_done_q <= 1'b0;
                d_done_q <= 1'b0;
            end
            case (state_q)
                rv_pkg::ARB_IDLE: begin
                    // Data side first, it holds the older instruction
                    if (d_pend || i_pend) begin
                        state_q   <= rv_pkg::ARB_REQ;
                        serve_d_q <= d_pend;
                        mem_wen_o <= d_pend && dmem_wen_i;
                    end
                end
                rv_pkg::ARB_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= rv_pkg::ARB_RELEASE;
                        if (serve_d_q) begin
                            d_done_q <= 1'b1;
                        end else begin
                            i_done_q <= 1'b1;
                        end
                    end
                end
                rv_pkg::ARB_RELEASE: begin
                    if (!mem_ack_i) begin
                        state_q <= rv_pkg::ARB_IDLE;
                    end
                end
                default: state_q <= rv_pkg::ARB_IDLE;
            endcase
        end
    end

    // Bus payload only moves while idle
    always_ff @(posedge clk) begin
        if (state_q == rv_pkg::ARB_IDLE) begin
            mem_addr_o  <= d_pend ? dmem_addr_i : imem_addr_i;
            mem_wdata_o <= dmem_wdata_i;
        end
        if (state_q == rv_pkg::ARB_REQ && mem_ack_i) begin
            if (serve_d_q) begin
                dmem_rdata_o <= mem_rdata_i;
            end else begin
                imem_rdata_o <= mem_rdata_i;
            end
        end
    end

endmodule

//--- src/rv_subsystem.sv
module rv_subsystem #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                      MEM_AW   = 30
) (
    input  logic                    clk,
    input  logic                    rst_i,
    output logic                    mem_req_o,
    output logic                    mem_wen_o,
    output logic [MEM_AW-1:0]       mem_addr_o,
    output logic [rv_pkg::XLEN-1:0] mem_wdata_o,
    input  logic                    mem_ack_i,
    input  logic [rv_pkg::XLEN-1:0] mem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] pc_o
);

    logic                    imem_ren, imem_stall, dmem_ren, dmem_wen, dmem_stall;
    logic [MEM_AW-1:0]       imem_addr, dmem_addr;
    logic [rv_pkg::XLEN-1:0] imem_rdata, dmem_rdata, dmem_wdata;

    rv_core #(
        .RESET_PC (RESET_PC),
        .MEM_AW   (MEM_AW)
    ) u_core (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_ren_o   (imem_ren),
        .imem_addr_o  (imem_addr),
        .imem_stall_i (imem_stall),
        .imem_rdata_i (imem_rdata),
        .dmem_ren_o   (dmem_ren),
        .dmem_wen_o   (dmem_wen),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_stall_i (dmem_stall),
        .dmem_rdata_i (dmem_rdata),
        .pc_o         (pc_o)
    );

    // Single shared bus to external memory
    rv_mem_arbiter #(
        .MEM_AW (MEM_AW)
    ) u_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_ren_i   (imem_ren),
        .imem_addr_i  (imem_addr),
        .imem_stall_o (imem_stall),
        .imem_rdata_o (imem_rdata),
        .dmem_ren_i   (dmem_ren),
        .dmem_wen_i   (dmem_wen),
        .dmem_addr_i  (dmem_addr),
        .dmem_wdata_i (dmem_wdata),
        .dmem_stall_o (dmem_stall),
        .dmem_rdata_o (dmem_rdata),
        .mem_req_o    (mem_req_o),
        .mem_wen_o    (mem_wen_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

//--- dv/tb_rv_subsystem.sv
module tb_rv_subsystem;

    localparam int              XLEN         = rv_pkg::XLEN;
    localparam int              MEM_AW       = 10;
    localparam int              MEM_WORDS    = 2**MEM_AW;
    localparam logic [XLEN-1:0] RESET_PC     = '0;
    localparam logic [XLEN-1:0] HALT_ADDR    = 32'h0000_0ffc;
    localparam int              WORST_ACCESS = 8;
    localparam int              DRAIN_CYCLES = 200;
    localparam int              NUM_DELAYS   = 256;

    logic              clk, rst_i, mem_ack_i, mem_req_o, mem_wen_o;
    logic [MEM_AW-1:0] mem_addr_o;
    logic [XLEN-1:0]   mem_rdata_i, mem_wdata_o, pc_o;

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [XLEN-1:0]   ref_mem [MEM_WORDS];
    logic [MEM_AW-1:0] exp_addr [$];
    logic [XLEN-1:0]   exp_data [$];
    logic [XLEN-1:0]   loop_pc;
    int                delays [NUM_DELAYS];
    int                load_ptr, delay_ptr, wait_cnt, store_idx, cycles, cycle_limit;
    logic              halted, req_q, wen_q, ack_seen, fetch_seen;
    logic [MEM_AW-1:0] addr_q;
    logic [XLEN-1:0]   wdata_q;

    rv_subsystem #(
        .RESET_PC (RESET_PC),
        .MEM_AW   (MEM_AW)
    ) u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_req_o   (mem_req_o),
        .mem_wen_o   (mem_wen_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .pc_o        (pc_o)
    );

    // Memory is big-endian while the ISA view is little-endian
    function automatic logic [XLEN-1:0] byte_swap(input logic [XLEN-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [XLEN-1:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [XLEN-1:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input rv_pkg::opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [XLEN-1:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic logic [XLEN-1:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    function automatic logic [XLEN-1:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    task automatic emit(input logic [XLEN-1:0] instr);
        mem[load_ptr] = byte_swap(instr);
        load_ptr++;
    endtask

    task automatic load_program();
        load_ptr = 0;
        // ALU chain with back-to-back use
        emit(u_type(20'h12345, 1));
        emit(i_type(12'h678, 1, 3'b000, 2, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'h400, 0, 3'b000, 10, rv_pkg::OPC_OP_IMM));
        emit(r_type(7'h20, 1, 2, 3'b000, 3));
        emit(r_type(7'h00, 2, 3, 3'b111, 4));
        emit(r_type(7'h00, 1, 4, 3'b110, 5));
        emit(r_type(7'h00, 3, 5, 3'b100, 6));
        emit(r_type(7'h00, 2, 3, 3'b010, 7));
        emit(i_type(12'hffb, 0, 3'b000, 8, rv_pkg::OPC_OP_IMM));
        emit(r_type(7'h00, 7, 8, 3'b010, 9));
        emit(s_type(12'd0, 2, 10));
        emit(s_type(12'd4, 3, 10));
        emit(s_type(12'd8, 6, 10));
        emit(r_type(7'h00, 9, 7, 3'b000, 11));
        emit(s_type(12'd12, 11, 10));
        emit(s_type(12'd16, 8, 10));
        // Load-use into ADD and into BNE
        emit(i_type(12'd0, 10, 3'b010, 12, rv_pkg::OPC_LOAD));
        emit(r_type(7'h00, 7, 12, 3'b000, 13));
        emit(s_type(12'd20, 13, 10));
        emit(i_type(12'd4, 10, 3'b010, 14, rv_pkg::OPC_LOAD));
        emit(b_type(13'd8, 3, 14, 3'b001));
        emit(s_type(12'd24, 14, 10));
        emit(i_type(12'd16, 10, 3'b010, 15, rv_pkg::OPC_LOAD));
        emit(b_type(13'd8, 0, 15, 3'b001));
        // Shadow of a taken branch
        emit(s_type(12'd28, 0, 10));
        emit(i_type(12'd10, 15, 3'b000, 16, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'hffb, 16, 3'b000, 17, rv_pkg::OPC_OP_IMM));
        emit(b_type(13'd8, 0, 17, 3'b000));
        emit(s_type(12'd32, 16, 10));
        emit(b_type(13'd8, 0, 16, 3'b000));
        emit(s_type(12'd36, 16, 10));
        // JAL over two stores and JALR on a fresh register
        emit(j_type(21'd12, 18));
        emit(s_type(12'd40, 0, 10));
        emit(s_type(12'd44, 0, 10));
        emit(s_type(12'd48, 18, 10));
        emit(i_type(12'd160, 0, 3'b000, 19, rv_pkg::OPC_OP_IMM));
        emit(i_type(12'd4, 19, 3'b000, 20, rv_pkg::OPC_JALR));
        repeat (4) emit(s_type(12'd52, 0, 10));
        emit(s_type(12'd56, 20, 10));
        // Halt store and self-loop
        emit(u_type(20'h00001, 31));
        emit(i_type(12'hffc, 31, 3'b000, 31, rv_pkg::OPC_OP_IMM));
        emit(s_type(12'd0, 2, 31));
        emit(j_type(21'd0, 0));
    endtask

    function automatic logic [XLEN-1:0] exec_alu(input logic [2:0] f3, input logic sub,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // Instruction-set model that returns the executed count or 0 without a halt store
    function automatic int run_reference();
        logic [XLEN-1:0] rf [32];
        logic [XLEN-1:0] pc, next_pc, ins, a, b, imm_i, imm_s, imm_b, imm_j, addr, val;
        logic            wr;
        for (int r = 0; r < 32; r++) begin
            rf[r] = '0;
        end
        pc = RESET_PC;
        for (int n = 0; n < 4096; n++) begin
            ins     = byte_swap(ref_mem[pc[MEM_AW+1:2]]);
            a       = rf[ins[19:15]];
            b       = rf[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            val     = pc + 32'd4;
            wr      = 1'b1;
            case (rv_pkg::opcode_e'(ins[6:0]))
                rv_pkg::OPC_LUI:    val = {ins[31:12], 12'b0};
                rv_pkg::OPC_OP_IMM: val = exec_alu(ins[14:12], 1'b0, a, imm_i);
                rv_pkg::OPC_OP:     val = exec_alu(ins[14:12], ins[30], a, b);
                rv_pkg::OPC_LOAD: begin
                    addr = a + imm_i;
                    val  = byte_swap(ref_mem[addr[MEM_AW+1:2]]);
                end
                rv_pkg::OPC_STORE: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    exp_addr.push_back(addr[MEM_AW+1:2]);
                    exp_data.push_back(byte_swap(b));
                    ref_mem[addr[MEM_AW+1:2]] = byte_swap(b);
                    if (addr == HALT_ADDR) begin
                        // Self-loop follows the halt store
                        loop_pc = pc + 32'd4;
                        return n + 1;
                    end
                end
                rv_pkg::OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + imm_b;
                    end
                end
                rv_pkg::OPC_JAL:  next_pc = pc + imm_j;
                rv_pkg::OPC_JALR: next_pc = (a + imm_i) & ~32'd1;
                default:          wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                rf[ins[11:7]] = val;
            end
            pc = next_pc;
        end
        return 0;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_bus(input logic ok, input string what);
        rv_pkg::arb_state_e st;
        if (!ok) begin
            st = u_dut.u_arbiter.state_q;
            stop_run($sformatf("Bus protocol error: %s (arbiter in %s)", what, st.name()));
        end
    endtask

    task automatic check_store(input logic [MEM_AW-1:0] addr, input logic [XLEN-1:0] data);
        if (store_idx >= exp_data.size()) begin
            stop_run("A write appeared on the bus after the last reference store");
        end
        if (addr !== exp_addr[store_idx]) begin
            stop_run($sformatf("[FAIL] mem_addr_o expected %h actual %h",
                               exp_addr[store_idx], addr));
        end
        if (data !== exp_data[store_idx]) begin
            stop_run($sformatf("[FAIL] mem_wdata_o expected %h actual %h",
                               exp_data[store_idx], data));
        end
        store_idx++;
        if (addr == HALT_ADDR[MEM_AW+1:2]) begin
            halted = 1'b1;
        end
    endtask

    // The self-loop alternates between the JAL and the flushed word after it
    task automatic check_pc(input logic [XLEN-1:0] exp_pc, input logic [XLEN-1:0] pc);
        if (pc !== exp_pc && pc !== exp_pc + 32'd4) begin
            stop_run($sformatf("[FAIL] pc_o expected %h or %h actual %h",
                               exp_pc, exp_pc + 32'd4, pc));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory answers each req after a table-driven random delay
    always @(posedge clk) begin
        if (rst_i) begin
            mem_ack_i <= 1'b0;
            wait_cnt  <= delays[0];
            delay_ptr <= 1;
        end else if (mem_req_o && !mem_ack_i) begin
            if (wait_cnt == 0) begin
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= mem[mem_addr_o];
                if (mem_wen_o) begin
                    mem[mem_addr_o] <= mem_wdata_o;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (!mem_req_o && mem_ack_i) begin
            mem_ack_i <= 1'b0;
            wait_cnt  <= delays[delay_ptr];
            delay_ptr <= (delay_ptr + 1) % NUM_DELAYS;
        end
    end

    // Bus monitor and store comparison
    always @(posedge clk) begin
        if (rst_i) begin
            req_q      <= 1'b0;
            ack_seen   <= 1'b0;
            fetch_seen <= 1'b0;
            cycles     <= 0;
        end else begin
            cycles <= cycles + 1;
            if (!halted && cycles >= cycle_limit) begin
                stop_run($sformatf("Timeout: no halt store within %0d cycles", cycle_limit));
            end
            if (mem_req_o && !req_q) begin
                check_bus(!mem_ack_i, "mem_req_o rose while mem_ack_i was still high");
                if (mem_wen_o) begin
                    check_bus(fetch_seen, "write issued before the first fetch completed");
                    check_store(mem_addr_o, mem_wdata_o);
                end
            end
            if (mem_req_o && req_q) begin
                check_bus(mem_addr_o === addr_q && mem_wen_o === wen_q &&
                          mem_wdata_o === wdata_q, "payload changed while mem_req_o was high");
            end
            if (!mem_req_o && req_q) begin
                check_bus(ack_seen, "mem_req_o dropped before mem_ack_i rose");
            end
            if (mem_req_o && mem_ack_i) begin
                ack_seen <= 1'b1;
                if (!mem_wen_o) begin
                    fetch_seen <= 1'b1;
                end
            end else if (!mem_req_o) begin
                ack_seen <= 1'b0;
            end
            req_q   <= mem_req_o;
            addr_q  <= mem_addr_o;
            wen_q   <= mem_wen_o;
            wdata_q <= mem_wdata_o;
        end
    end

    initial begin
        int icount;
        void'($urandom(32'h0f018aa8));
        rst_i       = 1'b1;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        halted      = 1'b0;
        store_idx   = 0;
        for (int i = 0; i < NUM_DELAYS; i++) begin
            delays[i] = $urandom_range(4, 0);
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = 32'hd0a7_0000 | a;
        end
        load_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_mem[a] = mem[a];
        end
        icount = run_reference();
        if (icount == 0) begin
            stop_run("Reference model never reached the halt store");
        end
        cycle_limit = 40 * icount * WORST_ACCESS;
        $display("Reference: %0d instructions, %0d stores", icount, exp_data.size());
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        wait (halted);
        // Catch any stray write after the halt store
        repeat (DRAIN_CYCLES) @(posedge clk);
        check_pc(loop_pc, pc_o);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- files.f
src/rv_pkg.sv
src/rv_decode.sv
src/rv_alu.sv
src/rv_core.sv
src/rv_mem_arbiter.sv
src/rv_subsystem.sv
dv/tb_rv_subsystem.sv
